/* vlog.f */
npp_pkg.sv
nsu_txn_ctrl.sv
nsu_rdata_fifo.sv
nsu_flit_builder.sv
nsu_packet_top.sv
tb_nsu_model.sv
tb_nsu_packet.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator and run the packetizer testbench

cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_nsu_packet \
    -o tb_nsu_packet_sim &&
./obj_dir/tb_nsu_packet_sim | tee /dev/stderr | grep -q '^Simulation PASSED$' &&
echo "run_sim: pass" ||
{ echo "run_sim: fail"; exit 1; }

/* tb_nsu_packet.sv */
// testbench top with clock, reset, random AXI stimulus, credit return, watchdog and report
module tb_nsu_packet;
    timeunit 1ns;
    timeprecision 1ps;
    import npp_pkg::*;

    localparam int              NOC_CREDITS = 4;
    localparam int              FIFO_DEPTH  = 32;
    localparam logic [ID_W-1:0] SRC_ID      = 4'hF;
    localparam int              NUM_TXN     = 40;
    localparam int              MAX_BEATS   = 64;
    localparam int              CLK_PERIOD  = 100;
    localparam int              WATCHDOG_NS = NUM_TXN * 400 * CLK_PERIOD;

    logic      ddr_clk;
    logic      ddr_rst_n;
    hs_t       aw_snoop;
    ar_snoop_t ar_snoop;
    b_chan_t   b_chan;
    r_chan_t   r_chan;
    logic      credit_ret;
    logic      bready;
    logic      rready;
    noc_flit_t noc_out;
    logic      rd_req_done;

    int seed       = 65;
    int tb_errors  = 0;
    int sent       = 0;
    int returned   = 0;
    int stall_left = 0;
    int txn;

    nsu_packet_top #(
        .NOC_CREDITS (NOC_CREDITS),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .SRC_ID      (SRC_ID)
    ) dut (
        .ddr_clk     (ddr_clk),
        .ddr_rst_n   (ddr_rst_n),
        .aw_snoop    (aw_snoop),
        .ar_snoop    (ar_snoop),
        .b_chan      (b_chan),
        .r_chan      (r_chan),
        .credit_ret  (credit_ret),
        .bready      (bready),
        .rready      (rready),
        .noc_out     (noc_out),
        .rd_req_done (rd_req_done)
    );

    tb_nsu_model #(
        .SRC_ID    (SRC_ID),
        .MAX_BEATS (MAX_BEATS)
    ) model (
        .ddr_clk     (ddr_clk),
        .ddr_rst_n   (ddr_rst_n),
        .noc_out     (noc_out),
        .rd_req_done (rd_req_done)
    );

    initial ddr_clk = 1'b0;
    always #(CLK_PERIOD / 2) ddr_clk = ~ddr_clk;

    task automatic print_counts();
        $display("error count: model %0d, testbench %0d", model.error_count(), tb_errors);
    endtask

    task automatic run_write();
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
        id   = ID_W'($random(seed));
        resp = 2'($random(seed));
        model.expect_write(id, resp);
        aw_snoop = '{valid: 1'b1, ready: 1'b1};
        @(negedge ddr_clk);
        aw_snoop = '0;
        repeat ($random(seed) & 3) @(negedge ddr_clk);
        b_chan = '{bvalid: 1'b1, bid: id, bresp: resp};
        while (!bready) @(negedge ddr_clk);
        @(negedge ddr_clk);
        b_chan = '0;
    endtask

    task automatic run_read();
        logic [ID_W-1:0]   id;
        logic [LEN_W-1:0]  len;
        logic [FLIT_W-1:0] beats [MAX_BEATS];
        int                i;
        id  = ID_W'($random(seed));
        len = LEN_W'($random(seed) & 63);
        for (i = 0; i < MAX_BEATS; i++) begin
            beats[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        model.expect_read(id, len, beats);
        ar_snoop = '{hs: '{valid: 1'b1, ready: 1'b1}, arid: id, arlen: len};
        @(negedge ddr_clk);
        ar_snoop = '0;
        for (i = 0; i <= int'(len); i++) begin
            repeat ($random(seed) & 3) @(negedge ddr_clk);
            r_chan = '{rvalid: 1'b1, rid: id, rdata: beats[i], rresp: 2'b00,
                       rlast: (i == int'(len))};
            // rready only moves on the rising edge
            while (!rready) @(negedge ddr_clk);
            @(negedge ddr_clk);
            r_chan.rvalid = 1'b0;
            r_chan.rlast  = 1'b0;
        end
    endtask

    // controller needs the job_done cycle plus one before it accepts again
    task automatic wait_drain();
        while (model.pending_flits() != 0) @(posedge ddr_clk);
        repeat (2 + ($random(seed) & 3)) @(negedge ddr_clk);
    endtask

    // credit return with random delay and occasional long stalls
    always @(negedge ddr_clk) begin
        if (ddr_rst_n) begin
            if (credit_ret)
                returned++;
            if (noc_out.vld)
                sent++;
            if (sent - returned > NOC_CREDITS) begin
                tb_errors++;
                $display("credit limit broken at %0t: %0d flits outstanding",
                         $time, sent - returned);
            end
            if (stall_left > 0)
                stall_left--;
            else if (($random(seed) & 63) == 0)
                stall_left = 20 + ($random(seed) & 31);
            credit_ret = (stall_left == 0) && (sent > returned) && (($random(seed) & 1) != 0);
        end
    end

    initial begin
        ddr_rst_n  = 1'b0;
        aw_snoop   = '0;
        ar_snoop   = '0;
        b_chan     = '0;
        r_chan     = '0;
        credit_ret = 1'b0;
        repeat (16) @(negedge ddr_clk);
        ddr_rst_n = 1'b1;
        @(negedge ddr_clk);
        if (bready || rready || noc_out.vld || rd_req_done) begin
            tb_errors++;
            $display("outputs not idle after reset at %0t", $time);
        end
        for (txn = 0; txn < NUM_TXN; txn++) begin
            if (($random(seed) & 1) != 0)
                run_read();
            else
                run_write();
            wait_drain();
        end
        print_counts();
        if (model.error_count() == 0 && tb_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        tb_errors++;
        $display("timeout after %0d ns, transactions did not complete", WATCHDOG_NS);
        print_counts();
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* tb_nsu_model.sv */
// reference model with expected-flit queue, monitor and typed compare tasks
module tb_nsu_model #(
    parameter logic [npp_pkg::ID_W-1:0] SRC_ID    = 4'hF,
    parameter int                       MAX_BEATS = 64
) (
    input logic               ddr_clk,
    input logic               ddr_rst_n,
    input npp_pkg::noc_flit_t noc_out,
    input logic               rd_req_done
);
    timeunit 1ns;
    timeprecision 1ps;
    import npp_pkg::*;

    noc_flit_t exp_q [$];
    bit        last_q [$];
    noc_flit_t exp_flit;
    bit        done_due = 1'b0;
    int        errors = 0;

    // layout from the flit table, codes and source fixed per flit kind
    function automatic logic [FLIT_W-1:0] make_ctrl(input logic [3:0] code_h,
        input logic [3:0] dest, input logic [2:0] typ, input logic [15:0] field,
        input logic [3:0] code_e);
        logic [FLIT_W-1:0] f;
        f = '0;
        f[127:124] = code_h;
        f[123:120] = SRC_ID;
        f[119:116] = dest;
        f[115:113] = typ;
        f[112:97]  = field;
        f[56:53]   = code_e;
        return f;
    endfunction

    function automatic int pending_flits();
        return exp_q.size();
    endfunction

    function automatic int error_count();
        return errors;
    endfunction

    task automatic add_flit(input bit head, input bit tail, input logic [FLIT_W-1:0] data,
        input bit last_rd);
        exp_q.push_back('{vld: 1'b1, is_head: head, is_tail: tail, data: data});
        last_q.push_back(last_rd);
    endtask

    task automatic expect_write(input logic [ID_W-1:0] bid, input logic [1:0] bresp);
        add_flit(1'b1, 1'b0, make_ctrl(4'hA, bid, 3'd3, 16'h0001, 4'hB), 1'b0);
        add_flit(1'b0, 1'b0, {{(FLIT_W - 2){1'b0}}, bresp}, 1'b0);
        add_flit(1'b0, 1'b1, make_ctrl(4'hC, bid, 3'd3, 16'h0001, 4'hD), 1'b0);
    endtask

    task automatic expect_read(input logic [ID_W-1:0] arid, input logic [LEN_W-1:0] arlen,
        input logic [FLIT_W-1:0] beats [MAX_BEATS]);
        int                 npkt;
        int                 nbeat;
        int                 b;
        int                 k;
        int                 j;
        logic [ORDER_W-1:0] cnt;
        npkt = int'(arlen) / 16 + 1;
        cnt  = ORDER_W'(1) << (npkt - 1);
        b    = 0;
        for (k = 0; k < npkt; k++) begin
            // only the final packet carries the remainder
            nbeat = (k == npkt - 1) ? (int'(arlen) % 16 + 1) : 16;
            add_flit(1'b1, 1'b0, make_ctrl(4'hA, arid, 3'd1, ORDER_W'(1) << k, 4'hB), 1'b0);
            for (j = 0; j < nbeat; j++) begin
                add_flit(1'b0, 1'b0, beats[b], 1'b0);
                b++;
            end
            add_flit(1'b0, 1'b1, make_ctrl(4'hC, arid, 3'd1, cnt, 4'hD), k == npkt - 1);
        end
    endtask

    task automatic check_flit(input noc_flit_t exp, input noc_flit_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: noc_out expected %h, got %h", $time, exp, act);
        end
    endtask

    task automatic check_done(input bit exp, input bit act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: rd_req_done expected %0b, got %0b", $time, exp, act);
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge ddr_clk) begin
        if (ddr_rst_n) begin
            check_done(done_due, rd_req_done);
            done_due = 1'b0;
            if (noc_out.vld) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("flit at %0t arrived while no flit was expected", $time);
                end else begin
                    exp_flit = exp_q.pop_front();
                    done_due = last_q.pop_front();
                    check_flit(exp_flit, noc_out);
                end
            end
        end
    end

endmodule

/* nsu_packet_top.sv */
// NoC slave unit packetizer top with transaction control, read FIFO and flit builder
module nsu_packet_top #(
    parameter int                       NOC_CREDITS = 4,
    parameter int                       FIFO_DEPTH  = 32,
    parameter logic [npp_pkg::ID_W-1:0] SRC_ID      = 4'hF
) (
    input  logic                ddr_clk,
    input  logic                ddr_rst_n,
    input  npp_pkg::hs_t        aw_snoop,
    input  npp_pkg::ar_snoop_t  ar_snoop,
    input  npp_pkg::b_chan_t    b_chan,
    input  npp_pkg::r_chan_t    r_chan,
    input  logic                credit_ret,
    output logic                bready,
    output logic                rready,
    output npp_pkg::noc_flit_t  noc_out,
    output logic                rd_req_done
);
    import npp_pkg::*;

    logic              fifo_push;
    logic              fifo_pop;
    logic              fifo_full;
    logic              fifo_empty;
    logic [FLIT_W-1:0] fifo_din;
    logic [FLIT_W-1:0] fifo_dout;
    pkt_job_t          job;
    logic              job_start;
    logic              job_done;

    nsu_txn_ctrl u_txn_ctrl (
        .ddr_clk     (ddr_clk),
        .ddr_rst_n   (ddr_rst_n),
        .aw_snoop    (aw_snoop),
        .ar_snoop    (ar_snoop),
        .b_chan      (b_chan),
        .r_chan      (r_chan),
        .fifo_full   (fifo_full),
        .job_done    (job_done),
        .bready      (bready),
        .rready      (rready),
        .fifo_push   (fifo_push),
        .fifo_din    (fifo_din),
        .job         (job),
        .job_start   (job_start),
        .rd_req_done (rd_req_done)
    );

    nsu_rdata_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_rdata_fifo (
        .ddr_clk   (ddr_clk),
        .ddr_rst_n (ddr_rst_n),
        .push      (fifo_push),
        .din       (fifo_din),
        .pop       (fifo_pop),
        .dout      (fifo_dout),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    nsu_flit_builder #(
        .NOC_CREDITS (NOC_CREDITS),
        .SRC_ID      (SRC_ID)
    ) u_flit_builder (
        .ddr_clk    (ddr_clk),
        .ddr_rst_n  (ddr_rst_n),
        .job        (job),
        .job_start  (job_start),
        .fifo_dout  (fifo_dout),
        .fifo_empty (fifo_empty),
        .credit_ret (credit_ret),
        .fifo_pop   (fifo_pop),
        .noc_out    (noc_out),
        .job_done   (job_done)
    );

endmodule

/* nsu_flit_builder.sv */
// head, body and tail sequencing with packet split, one-hot order and count, NoC credits
module nsu_flit_builder #(
    parameter int                        NOC_CREDITS = 4,
    parameter logic [npp_pkg::ID_W-1:0]  SRC_ID      = 4'hF
) (
    input  logic                       ddr_clk,
    input  logic                       ddr_rst_n,
    input  npp_pkg::pkt_job_t          job,
    input  logic                       job_start,
    input  logic [npp_pkg::FLIT_W-1:0] fifo_dout,
    input  logic                       fifo_empty,
    input  logic                       credit_ret,
    output logic                       fifo_pop,
    output npp_pkg::noc_flit_t         noc_out,
    output logic                       job_done
);
    import npp_pkg::*;

    localparam int FC_W = $clog2(MAX_DATA_FLITS);
    localparam int PC_W = LEN_W - FC_W;
    localparam int CR_W = $clog2(NOC_CREDITS + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEAD,
        ST_BODY,
        ST_TAIL
    } state_e;

    state_e             state_q;
    state_e             state_d;
    logic [FC_W-1:0]    flit_q;
    logic [PC_W-1:0]    pkt_q;
    logic [ORDER_W-1:0] order_q;
    logic [CR_W-1:0]    credits_q;
    logic               is_rd;
    logic               can_send;
    logic               send;
    logic               done_d;
    logic               last_pkt;
    logic               last_beat;
    logic [FC_W-1:0]    last_idx;
    logic [ORDER_W-1:0] count_field;
    logic [FLIT_W-1:0]  body_data;
    noc_flit_t          flit_d;
    logic               vld_q;
    logic               head_q;
    logic               tail_q;
    logic [FLIT_W-1:0]  data_q;

    assign is_rd    = (job.ftype == TYPE_RD_DATA);
    assign can_send = (credits_q != '0);

    // upper length bits give packet count minus one, lower bits the last remainder
    assign last_pkt    = (pkt_q == job.len[LEN_W-1:FC_W]);
    assign last_idx    = last_pkt ? job.len[FC_W-1:0] : FC_W'(MAX_DATA_FLITS - 1);
    assign last_beat   = (flit_q == last_idx);
    assign count_field = ORDER_W'(1) << job.len[LEN_W-1:FC_W];

    // write response body carries bresp alone
    assign body_data = is_rd ? fifo_dout : {{(FLIT_W - 2){1'b0}}, job.bresp};

    always_comb begin
        state_d  = state_q;
        send     = 1'b0;
        done_d   = 1'b0;
        fifo_pop = 1'b0;
        flit_d   = '0;
        case (state_q)
            ST_IDLE: begin
                if (job_start)
                    state_d = ST_HEAD;
            end
            ST_HEAD: begin
                if (can_send) begin
                    send           = 1'b1;
                    flit_d.is_head = 1'b1;
                    flit_d.data    = ctrl_flit(HEAD_CODE_H, SRC_ID, job.dest, job.ftype,
                                               order_q, HEAD_CODE_E);
                    state_d        = ST_BODY;
                end
            end
            ST_BODY: begin
                if (can_send && (!is_rd || !fifo_empty)) begin
                    send        = 1'b1;
                    fifo_pop    = is_rd;
                    flit_d.data = body_data;
                    if (last_beat)
                        state_d = ST_TAIL;
                end
            end
            ST_TAIL: begin
                if (can_send) begin
                    send           = 1'b1;
                    flit_d.is_tail = 1'b1;
                    flit_d.data    = ctrl_flit(TAIL_CODE_H, SRC_ID, job.dest, job.ftype,
                                               count_field, TAIL_CODE_E);
                    if (last_pkt) begin
                        state_d = ST_IDLE;
                        done_d  = 1'b1;
                    end else begin
                        state_d = ST_HEAD;
                    end
                end
            end
            default: state_d = ST_IDLE;
        endcase
        flit_d.vld = send;
    end

    always_ff @(posedge ddr_clk or negedge ddr_rst_n) begin
        if (!ddr_rst_n) begin
            state_q   <= ST_IDLE;
            flit_q    <= '0;
            pkt_q     <= '0;
            order_q   <= ORDER_W'(1);
            credits_q <= CR_W'(NOC_CREDITS);
            vld_q     <= 1'b0;
            head_q    <= 1'b0;
            tail_q    <= 1'b0;
            job_done  <= 1'b0;
        end else begin
            state_q  <= state_d;
            vld_q    <= flit_d.vld;
            head_q   <= flit_d.is_head;
            tail_q   <= flit_d.is_tail;
            job_done <= done_d;
            if (state_q == ST_IDLE && job_start) begin
                flit_q  <= '0;
                pkt_q   <= '0;
                order_q <= ORDER_W'(1);
            end else if (send && state_q == ST_BODY) begin
                flit_q <= last_beat ? '0 : flit_q + 1'b1;
            end else if (send && state_q == ST_TAIL) begin
                pkt_q   <= pkt_q + 1'b1;
                order_q <= {order_q[ORDER_W-2:0], order_q[ORDER_W-1]};
            end
            // one credit per flit sent, one back per return pulse
            case ({send, credit_ret})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;
            endcase
        end
    end

    always_ff @(posedge ddr_clk) begin
        data_q <= flit_d.data;
    end

    assign noc_out = '{vld: vld_q, is_head: head_q, is_tail: tail_q, data: data_q};

    a_credit_max: assert property (@(posedge ddr_clk) disable iff (!ddr_rst_n)
        credits_q <= CR_W'(NOC_CREDITS));

    a_credit_held: assert property (@(posedge ddr_clk) disable iff (!ddr_rst_n)
        noc_out.vld |-> ($past(credits_q) != '0));

endmodule

/* nsu_rdata_fifo.sv */
// synchronous register-array FIFO holding read beats for the flit builder
module nsu_rdata_fifo #(
    parameter int DEPTH = 32
) (
    input  logic                       ddr_clk,
    input  logic                       ddr_rst_n,
    input  logic                       push,
    input  logic [npp_pkg::FLIT_W-1:0] din,
    input  logic                       pop,
    output logic [npp_pkg::FLIT_W-1:0] dout,
    output logic                       full,
    output logic                       empty
);
    import npp_pkg::*;

    localparam int AW = $clog2(DEPTH);

    logic [FLIT_W-1:0] mem [DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [AW:0]       count;

    // wraps at DEPTH, so a non power of two depth also works
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign dout  = mem[rd_ptr];
    assign full  = (count == (AW + 1)'(DEPTH));
    assign empty = (count == '0);

    always_ff @(posedge ddr_clk) begin
        if (push)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge ddr_clk or negedge ddr_rst_n) begin
        if (!ddr_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge ddr_clk) disable iff (!ddr_rst_n)
        push |-> !full);

    a_no_underflow: assert property (@(posedge ddr_clk) disable iff (!ddr_rst_n)
        pop |-> !empty);

endmodule

/* nsu_txn_ctrl.sv */
// transaction FSM, bready and rready generation, job capture and read completion pulse
module nsu_txn_ctrl (
    input  logic                      ddr_clk,
    input  logic                      ddr_rst_n,
    input  npp_pkg::hs_t              aw_snoop,
    input  npp_pkg::ar_snoop_t        ar_snoop,
    input  npp_pkg::b_chan_t          b_chan,
    input  npp_pkg::r_chan_t          r_chan,
    input  logic                      fifo_full,
    input  logic                      job_done,
    output logic                      bready,
    output logic                      rready,
    output logic                      fifo_push,
    output logic [npp_pkg::FLIT_W-1:0] fifo_din,
    output npp_pkg::pkt_job_t         job,
    output logic                      job_start,
    output logic                      rd_req_done
);
    import npp_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SELECT,
        ST_WAIT_B,
        ST_WAIT_R
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   accept;
    logic   aw_take;
    logic   ar_take;
    logic   b_hs;
    logic   r_hs;
    logic   rlast_seen;
    logic   job_busy;

    // handshakes are only taken while no job is in flight
    assign accept  = (state_q == ST_IDLE) || (state_q == ST_SELECT);
    assign aw_take = accept && aw_snoop.valid && aw_snoop.ready;
    assign ar_take = accept && ar_snoop.hs.valid && ar_snoop.hs.ready && !aw_take;
    assign b_hs    = b_chan.bvalid && bready;
    assign r_hs    = r_chan.rvalid && rready;

    assign rready    = (state_q == ST_WAIT_R) && !rlast_seen && !fifo_full;
    assign fifo_push = r_hs;
    assign fifo_din  = r_chan.rdata;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE, ST_SELECT: begin
                if (aw_take)
                    state_d = ST_WAIT_B;
                else if (ar_take)
                    state_d = ST_WAIT_R;
                else
                    state_d = ST_SELECT;
            end
            ST_WAIT_B, ST_WAIT_R: begin
                if (job_done)
                    state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge ddr_clk or negedge ddr_rst_n) begin
        if (!ddr_rst_n) begin
            state_q     <= ST_IDLE;
            bready      <= 1'b0;
            rlast_seen  <= 1'b0;
            job_start   <= 1'b0;
            job_busy    <= 1'b0;
            rd_req_done <= 1'b0;
        end else begin
            state_q <= state_d;
            // bready opens on entry to the response wait, closes after one beat
            if (b_hs)
                bready <= 1'b0;
            else if (aw_take)
                bready <= 1'b1;
            if (accept)
                rlast_seen <= 1'b0;
            else if (r_hs && r_chan.rlast)
                rlast_seen <= 1'b1;
            job_start <= b_hs || ar_take;
            if (job_done)
                job_busy <= 1'b0;
            else if (job_start)
                job_busy <= 1'b1;
            rd_req_done <= (state_q == ST_WAIT_R) && job_done;
        end
    end

    // job payload, held stable until the builder reports done
    always_ff @(posedge ddr_clk) begin
        if (b_hs) begin
            job.ftype <= TYPE_BRESP;
            job.dest  <= b_chan.bid;
            job.len   <= '0;
            job.bresp <= b_chan.bresp;
        end else if (ar_take) begin
            job.ftype <= TYPE_RD_DATA;
            job.dest  <= ar_snoop.arid;
            job.len   <= ar_snoop.arlen;
            job.bresp <= 2'b00;
        end
    end

    a_ready_excl: assert property (@(posedge ddr_clk) disable iff (!ddr_rst_n)
        !(bready && rready));

    a_one_job: assert property (@(posedge ddr_clk) disable iff (!ddr_rst_n)
        job_start |-> !job_busy);

endmodule

/* npp_pkg.sv */
// flit layout constants, check codes, type codes, channel structs and control flit builder
package npp_pkg;

    localparam int FLIT_W         = 128;
    localparam int ID_W           = 4;
    localparam int ORDER_W        = 16;
    localparam int LEN_W          = 8;
    localparam int MAX_DATA_FLITS = 16;
    localparam int CODE_W         = 4;

    // reserved zero runs inside head and tail flits
    localparam int ZERO_MID_W = 40;
    localparam int ZERO_LOW_W = 53;

    localparam logic [CODE_W-1:0] HEAD_CODE_H = 4'hA;
    localparam logic [CODE_W-1:0] HEAD_CODE_E = 4'hB;
    localparam logic [CODE_W-1:0] TAIL_CODE_H = 4'hC;
    localparam logic [CODE_W-1:0] TAIL_CODE_E = 4'hD;

    typedef enum logic [2:0] {
        TYPE_RD_DATA = 3'd1,
        TYPE_BRESP   = 3'd3
    } flit_type_e;

    // observed handshake on an axi address channel
    typedef struct packed {
        logic valid;
        logic ready;
    } hs_t;

    typedef struct packed {
        hs_t              hs;
        logic [ID_W-1:0]  arid;
        logic [LEN_W-1:0] arlen;
    } ar_snoop_t;

    typedef struct packed {
        logic            bvalid;
        logic [ID_W-1:0] bid;
        logic [1:0]      bresp;
    } b_chan_t;

    typedef struct packed {
        logic              rvalid;
        logic [ID_W-1:0]   rid;
        logic [FLIT_W-1:0] rdata;
        logic [1:0]        rresp;
        logic              rlast;
    } r_chan_t;

    // one packetizing job handed to the flit builder
    typedef struct packed {
        flit_type_e       ftype;
        logic [ID_W-1:0]  dest;
        logic [LEN_W-1:0] len;
        logic [1:0]       bresp;
    } pkt_job_t;

    typedef struct packed {
        logic              vld;
        logic              is_head;
        logic              is_tail;
        logic [FLIT_W-1:0] data;
    } noc_flit_t;

    // head and tail share one layout, only codes and the one-hot field differ
    function automatic logic [FLIT_W-1:0] ctrl_flit(
        input logic [CODE_W-1:0]  code_h,
        input logic [ID_W-1:0]    src,
        input logic [ID_W-1:0]    dest,
        input flit_type_e         ftype,
        input logic [ORDER_W-1:0] field,
        input logic [CODE_W-1:0]  code_e
    );
        return {code_h, src, dest, ftype, field, {ZERO_MID_W{1'b0}},
                code_e, {ZERO_LOW_W{1'b0}}};
    endfunction

endpackage
